//--- design/arvi_pkg.sv
`default_nettype none

package arvi_pkg;

	// Data and address width of the hart
	localparam int xlen = 32;

	// Load/store width, encoded as funct3
	typedef enum logic [2:0] {
		width_b  = 3'b000,
		width_h  = 3'b001,
		width_w  = 3'b010,
		width_bu = 3'b100,
		width_hu = 3'b101
	} mem_width_e;

	// Command from the pipeline side
	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
		mem_width_e      width;
		logic            is_store;
	} ls_cmd_t;

	// Result back to the pipeline side
	typedef struct packed {
		logic [xlen-1:0] rdata;
		logic            misaligned;
	} ls_rsp_t;

	// Instruction word together with its address
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
	} fetch_t;

	// Bus master request, addr is always word aligned
	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
		logic [3:0]      byte_en;
		logic            wr_en;
	} bus_req_t;

	// Request from a client to the arbiter
	typedef struct packed {
		bus_req_t bus;
	} mem_req_t;

	// Arbiter states, busy states name the owner of the bus
	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_data
	} arb_state_e;

endpackage

`default_nettype wire

//--- design/instr_fetch.sv
`default_nettype none

module instr_fetch #(
	parameter logic [arvi_pkg::xlen-1:0] PC_RESET = '0
) (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst_n,

	// Request side towards the arbiter
	output logic                             o_req_valid,
	output arvi_pkg::mem_req_t               o_req,
	input  wire logic                        i_req_ready,
	input  wire logic                        i_rsp_valid,
	input  wire logic [arvi_pkg::xlen-1:0]   i_rsp_data,

	// Fetched instruction out
	output logic                             o_fetch_valid,
	output arvi_pkg::fetch_t                 o_fetch,
	input  wire logic                        i_fetch_ready,

	// PC redirect
	input  wire logic                        i_redirect_valid,
	input  wire logic [arvi_pkg::xlen-1:0]   i_redirect_pc
);

	typedef enum logic [1:0] {
		st_req,
		st_wait,
		st_hold
	} fetch_state_e;

	fetch_state_e                state_q;
	logic [arvi_pkg::xlen-1:0]   pc_q;
	logic [arvi_pkg::xlen-1:0]   instr_q;
	logic                        discard_q;

	assign o_req_valid   = (state_q == st_req);
	assign o_fetch_valid = (state_q == st_hold);
	assign o_fetch.pc    = pc_q;
	assign o_fetch.instr = instr_q;

	// Instruction reads are always full aligned words
	always_comb begin
		o_req.bus.addr    = {pc_q[arvi_pkg::xlen-1:2], 2'b00};
		o_req.bus.wdata   = '0;
		o_req.bus.byte_en = 4'b1111;
		o_req.bus.wr_en   = 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_q   <= st_req;
			pc_q      <= PC_RESET;
			discard_q <= 1'b0;
		end else if (i_redirect_valid) begin
			pc_q <= i_redirect_pc;
			// Old request already on its way, drop whatever comes back
			if ((state_q == st_req && i_req_ready) || (state_q == st_wait && !i_rsp_valid)) begin
				state_q   <= st_wait;
				discard_q <= 1'b1;
			end else begin
				state_q   <= st_req;
				discard_q <= 1'b0;
			end
		end else begin
			case (state_q)
				st_req: begin
					if (i_req_ready)
						state_q <= st_wait;
				end
				st_wait: begin
					if (i_rsp_valid) begin
						discard_q <= 1'b0;
						state_q   <= discard_q ? st_req : st_hold;
					end
				end
				st_hold: begin
					if (i_fetch_ready) begin
						pc_q    <= pc_q + 32'd4;
						state_q <= st_req;
					end
				end
				default: state_q <= st_req;
			endcase
		end
	end

	// Word held until the consumer takes it
	always_ff @(posedge i_clk) begin
		if (state_q == st_wait && i_rsp_valid)
			instr_q <= i_rsp_data;
	end

endmodule

`default_nettype wire

//--- design/load_store_unit.sv
`default_nettype none

module load_store_unit (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst_n,

	// Command port
	input  wire logic                        i_ls_valid,
	input  wire arvi_pkg::ls_cmd_t           i_ls_cmd,
	output logic                             o_ls_ready,

	// Response port
	output logic                             o_ls_rsp_valid,
	output arvi_pkg::ls_rsp_t                o_ls_rsp,
	input  wire logic                        i_ls_rsp_ready,

	// Request side towards the arbiter
	output logic                             o_req_valid,
	output arvi_pkg::mem_req_t               o_req,
	input  wire logic                        i_req_ready,
	input  wire logic                        i_rsp_valid,
	input  wire logic [arvi_pkg::xlen-1:0]   i_rsp_data
);

	typedef enum logic [1:0] {
		ls_idle,
		ls_req,
		ls_wait,
		ls_resp
	} lsu_state_e;

	lsu_state_e                  state_q;
	arvi_pkg::ls_cmd_t           cmd_q;
	logic [arvi_pkg::xlen-1:0]   rdata_q;
	logic                        mis_q;
	logic                        ls_accept;

	function automatic logic is_misaligned(input arvi_pkg::ls_cmd_t cmd);
		logic result;
		case (cmd.width)
			arvi_pkg::width_b, arvi_pkg::width_bu: result = 1'b0;
			arvi_pkg::width_h, arvi_pkg::width_hu: result = cmd.addr[0];
			default: result = |cmd.addr[1:0];
		endcase
		return result;
	endfunction

	function automatic logic [3:0] lane_enable(input arvi_pkg::ls_cmd_t cmd);
		logic [3:0] result;
		case (cmd.width)
			arvi_pkg::width_b, arvi_pkg::width_bu: result = 4'b0001 << cmd.addr[1:0];
			arvi_pkg::width_h, arvi_pkg::width_hu: result = 4'b0011 << {cmd.addr[1], 1'b0};
			default: result = 4'b1111;
		endcase
		return result;
	endfunction

	// Same value in every lane, byte_en picks the right one
	function automatic logic [31:0] lane_data(input arvi_pkg::ls_cmd_t cmd);
		logic [31:0] result;
		case (cmd.width)
			arvi_pkg::width_b, arvi_pkg::width_bu: result = {4{cmd.wdata[7:0]}};
			arvi_pkg::width_h, arvi_pkg::width_hu: result = {2{cmd.wdata[15:0]}};
			default: result = cmd.wdata;
		endcase
		return result;
	endfunction

	function automatic logic [31:0] load_format(input logic [31:0] word, input logic [1:0] offset,
			input arvi_pkg::mem_width_e width);
		logic [31:0] shifted;
		logic [31:0] result;
		shifted = word >> {offset, 3'b000};
		case (width)
			arvi_pkg::width_b:  result = {{24{shifted[7]}}, shifted[7:0]};
			arvi_pkg::width_bu: result = {24'b0, shifted[7:0]};
			arvi_pkg::width_h:  result = {{16{shifted[15]}}, shifted[15:0]};
			arvi_pkg::width_hu: result = {16'b0, shifted[15:0]};
			default: result = shifted;
		endcase
		return result;
	endfunction

	assign o_ls_ready          = (state_q == ls_idle);
	assign ls_accept           = i_ls_valid && o_ls_ready;
	assign o_ls_rsp_valid      = (state_q == ls_resp);
	assign o_ls_rsp.rdata      = rdata_q;
	assign o_ls_rsp.misaligned = mis_q;

	assign o_req_valid       = (state_q == ls_req);
	assign o_req.bus.addr    = {cmd_q.addr[arvi_pkg::xlen-1:2], 2'b00};
	assign o_req.bus.wdata   = lane_data(cmd_q);
	assign o_req.bus.byte_en = lane_enable(cmd_q);
	assign o_req.bus.wr_en   = cmd_q.is_store;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_q <= ls_idle;
		end else begin
			case (state_q)
				ls_idle: begin
					// Misaligned commands skip the bus entirely
					if (ls_accept)
						state_q <= is_misaligned(i_ls_cmd) ? ls_resp : ls_req;
				end
				ls_req: begin
					if (i_req_ready)
						state_q <= ls_wait;
				end
				ls_wait: begin
					if (i_rsp_valid)
						state_q <= ls_resp;
				end
				default: begin
					if (i_ls_rsp_ready)
						state_q <= ls_idle;
				end
			endcase
		end
	end

	// rdata starts at zero, which stores and misaligned commands keep
	always_ff @(posedge i_clk) begin
		if (ls_accept) begin
			cmd_q   <= i_ls_cmd;
			mis_q   <= is_misaligned(i_ls_cmd);
			rdata_q <= '0;
		end else if (state_q == ls_wait && i_rsp_valid && !cmd_q.is_store) begin
			rdata_q <= load_format(i_rsp_data, cmd_q.addr[1:0], cmd_q.width);
		end
	end

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst_n,

	// Instruction fetch client
	input  wire logic                        i_if_req_valid,
	input  wire arvi_pkg::mem_req_t          i_if_req,
	output logic                             o_if_req_ready,
	output logic                             o_if_rsp_valid,

	// Load/store client
	input  wire logic                        i_ls_req_valid,
	input  wire arvi_pkg::mem_req_t          i_ls_req,
	output logic                             o_ls_req_ready,
	output logic                             o_ls_rsp_valid,

	// Read data for whichever client owns the response
	output logic [arvi_pkg::xlen-1:0]        o_rsp_data,

	// Bus master
	output logic                             o_bus_en,
	output arvi_pkg::bus_req_t               o_bus_req,
	input  wire logic                        i_ack,
	input  wire logic [arvi_pkg::xlen-1:0]   i_rd_data
);

	arvi_pkg::arb_state_e state_q;
	logic                 grant_ls;
	logic                 grant_if;
	logic                 bus_done;

	// Data side wins a tie
	assign grant_ls = (state_q == arvi_pkg::st_idle) && i_ls_req_valid;
	assign grant_if = (state_q == arvi_pkg::st_idle) && i_if_req_valid && !i_ls_req_valid;
	assign bus_done = o_bus_en && i_ack;

	assign o_ls_req_ready = grant_ls;
	assign o_if_req_ready = grant_if;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_q        <= arvi_pkg::st_idle;
			o_bus_en       <= 1'b0;
			o_if_rsp_valid <= 1'b0;
			o_ls_rsp_valid <= 1'b0;
		end else begin
			// Responses are single cycle pulses
			o_if_rsp_valid <= 1'b0;
			o_ls_rsp_valid <= 1'b0;
			case (state_q)
				arvi_pkg::st_idle: begin
					if (grant_ls) begin
						state_q  <= arvi_pkg::st_data;
						o_bus_en <= 1'b1;
					end else if (grant_if) begin
						state_q  <= arvi_pkg::st_fetch;
						o_bus_en <= 1'b1;
					end
				end
				default: begin
					if (bus_done) begin
						o_bus_en       <= 1'b0;
						state_q        <= arvi_pkg::st_idle;
						o_if_rsp_valid <= (state_q == arvi_pkg::st_fetch);
						o_ls_rsp_valid <= (state_q == arvi_pkg::st_data);
					end
				end
			endcase
		end
	end

	// Request stays put for the whole transfer
	always_ff @(posedge i_clk) begin
		if (grant_ls)
			o_bus_req <= i_ls_req.bus;
		else if (grant_if)
			o_bus_req <= i_if_req.bus;
	end

	always_ff @(posedge i_clk) begin
		if (bus_done)
			o_rsp_data <= i_rd_data;
	end

endmodule

`default_nettype wire

//--- design/risc_v_mem_port.sv
`default_nettype none

module risc_v_mem_port #(
	parameter logic [arvi_pkg::xlen-1:0] PC_RESET = '0
) (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst_n,

	// Fetch
	output logic                             o_fetch_valid,
	output arvi_pkg::fetch_t                 o_fetch,
	input  wire logic                        i_fetch_ready,
	input  wire logic                        i_redirect_valid,
	input  wire logic [arvi_pkg::xlen-1:0]   i_redirect_pc,

	// Load/store
	input  wire logic                        i_ls_valid,
	input  wire arvi_pkg::ls_cmd_t           i_ls_cmd,
	output logic                             o_ls_ready,
	output logic                             o_ls_rsp_valid,
	output arvi_pkg::ls_rsp_t                o_ls_rsp,
	input  wire logic                        i_ls_rsp_ready,

	// Bus master
	output logic                             o_bus_en,
	output arvi_pkg::bus_req_t               o_bus_req,
	input  wire logic                        i_ack,
	input  wire logic [arvi_pkg::xlen-1:0]   i_rd_data
);

	logic                        if_req_valid;
	arvi_pkg::mem_req_t          if_req;
	logic                        if_req_ready;
	logic                        if_rsp_valid;

	logic                        ls_req_valid;
	arvi_pkg::mem_req_t          ls_req;
	logic                        ls_req_ready;
	logic                        ls_rsp_valid;

	// Shared read data, qualified by each client's rsp_valid
	logic [arvi_pkg::xlen-1:0]   rsp_data;

	instr_fetch #(
		.PC_RESET (PC_RESET)
	) u_instr_fetch (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.o_req_valid      (if_req_valid),
		.o_req            (if_req),
		.i_req_ready      (if_req_ready),
		.i_rsp_valid      (if_rsp_valid),
		.i_rsp_data       (rsp_data),
		.o_fetch_valid    (o_fetch_valid),
		.o_fetch          (o_fetch),
		.i_fetch_ready    (i_fetch_ready),
		.i_redirect_valid (i_redirect_valid),
		.i_redirect_pc    (i_redirect_pc)
	);

	load_store_unit u_load_store_unit (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_ls_valid     (i_ls_valid),
		.i_ls_cmd       (i_ls_cmd),
		.o_ls_ready     (o_ls_ready),
		.o_ls_rsp_valid (o_ls_rsp_valid),
		.o_ls_rsp       (o_ls_rsp),
		.i_ls_rsp_ready (i_ls_rsp_ready),
		.o_req_valid    (ls_req_valid),
		.o_req          (ls_req),
		.i_req_ready    (ls_req_ready),
		.i_rsp_valid    (ls_rsp_valid),
		.i_rsp_data     (rsp_data)
	);

	bus_arbiter u_bus_arbiter (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_if_req_valid (if_req_valid),
		.i_if_req       (if_req),
		.o_if_req_ready (if_req_ready),
		.o_if_rsp_valid (if_rsp_valid),
		.i_ls_req_valid (ls_req_valid),
		.i_ls_req       (ls_req),
		.o_ls_req_ready (ls_req_ready),
		.o_ls_rsp_valid (ls_rsp_valid),
		.o_rsp_data     (rsp_data),
		.o_bus_en       (o_bus_en),
		.o_bus_req      (o_bus_req),
		.i_ack          (i_ack),
		.i_rd_data      (i_rd_data)
	);

endmodule

`default_nettype wire

//--- tests/bus_memory_model.sv
`default_nettype none

module bus_memory_model (
	input  wire logic                        i_clk,
	input  wire logic                        i_bus_en,
	input  wire arvi_pkg::bus_req_t          i_bus_req,
	output logic                             o_ack,
	output logic [arvi_pkg::xlen-1:0]        o_rd_data
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] mem [0:1023];
	logic        busy;
	int unsigned delay;

	// Contents depend on every bit of the byte address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	// Read and write the addressed word, writes only touch enabled lanes
	task automatic serve();
		logic [9:0] idx;
		idx = i_bus_req.addr[11:2];
		o_rd_data = mem[idx];
		if (i_bus_req.wr_en) begin
			for (int b = 0; b < 4; b++) begin
				if (i_bus_req.byte_en[b])
					mem[idx][b*8 +: 8] = i_bus_req.wdata[b*8 +: 8];
			end
		end
	endtask

	initial begin
		o_ack = 1'b0;
		o_rd_data = '0;
		busy = 1'b0;
		delay = 0;
		for (int i = 0; i < 1024; i++)
			mem[i[9:0]] = fill_word(i * 4);
	end

	// Slave outputs change on the falling edge, ack lasts one cycle
	always @(negedge i_clk) begin
		if (o_ack) begin
			o_ack = 1'b0;
			busy = 1'b0;
		end else if (i_bus_en) begin
			if (!busy) begin
				busy = 1'b1;
				delay = $urandom % 4;
			end
			if (delay == 0) begin
				serve();
				o_ack = 1'b1;
			end else begin
				delay = delay - 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/bus_checker.sv
`default_nettype none

module bus_checker (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst_n,
	input  wire logic                        i_bus_en,
	input  wire arvi_pkg::bus_req_t          i_bus_req,
	input  wire logic                        i_ack,
	input  wire logic                        i_if_rsp_valid,
	input  wire logic                        i_ls_rsp_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	// Request held until the slave answers
	req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_bus_en && !i_ack |=> $stable(i_bus_req))
		else $error("bus request changed before ack");

	en_drop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_bus_en && i_ack |=> !i_bus_en)
		else $error("bus enable still high after ack");

	reset_quiet: assert property (@(posedge i_clk)
		!i_rst_n |=> !i_bus_en)
		else $error("bus enable high during reset");

	if_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_if_rsp_valid |=> !i_if_rsp_valid)
		else $error("fetch response valid longer than one cycle");

	ls_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_ls_rsp_valid |=> !i_ls_rsp_valid)
		else $error("data response valid longer than one cycle");

endmodule

bind bus_arbiter bus_checker u_bus_checker (
	.i_clk          (i_clk),
	.i_rst_n        (i_rst_n),
	.i_bus_en       (o_bus_en),
	.i_bus_req      (o_bus_req),
	.i_ack          (i_ack),
	.i_if_rsp_valid (o_if_rsp_valid),
	.i_ls_rsp_valid (o_ls_rsp_valid)
);

`default_nettype wire

//--- tests/tb_risc_v_mem_port.sv
`default_nettype none

module tb_risc_v_mem_port;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] PC_START = 32'h0000_0100;
	localparam int LIMIT = 200;

	logic                  clk;
	logic                  rst_n;
	logic                  fetch_ready;
	logic                  redirect_valid;
	logic [31:0]           redirect_pc;
	logic                  ls_valid;
	arvi_pkg::ls_cmd_t     ls_cmd;
	logic                  ls_rsp_ready;
	logic                  fetch_valid;
	arvi_pkg::fetch_t      fetch;
	logic                  ls_ready;
	logic                  ls_rsp_valid;
	arvi_pkg::ls_rsp_t     ls_rsp;
	logic                  bus_en;
	arvi_pkg::bus_req_t    bus_req;
	logic                  ack;
	logic [31:0]           rd_data;

	logic [31:0] mirror [0:1023];
	logic [31:0] exp_pc;

	risc_v_mem_port #(
		.PC_RESET (PC_START)
	) u_risc_v_mem_port (
		.i_clk            (clk),
		.i_rst_n          (rst_n),
		.o_fetch_valid    (fetch_valid),
		.o_fetch          (fetch),
		.i_fetch_ready    (fetch_ready),
		.i_redirect_valid (redirect_valid),
		.i_redirect_pc    (redirect_pc),
		.i_ls_valid       (ls_valid),
		.i_ls_cmd         (ls_cmd),
		.o_ls_ready       (ls_ready),
		.o_ls_rsp_valid   (ls_rsp_valid),
		.o_ls_rsp         (ls_rsp),
		.i_ls_rsp_ready   (ls_rsp_ready),
		.o_bus_en         (bus_en),
		.o_bus_req        (bus_req),
		.i_ack            (ack),
		.i_rd_data        (rd_data)
	);

	bus_memory_model u_bus_memory_model (
		.i_clk     (clk),
		.i_bus_en  (bus_en),
		.i_bus_req (bus_req),
		.o_ack     (ack),
		.o_rd_data (rd_data)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] initial_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic int byte_count(input arvi_pkg::mem_width_e w);
		case (w)
			arvi_pkg::width_b, arvi_pkg::width_bu: return 1;
			arvi_pkg::width_h, arvi_pkg::width_hu: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic arvi_pkg::mem_width_e width_at(input int k);
		case (k)
			0: return arvi_pkg::width_b;
			1: return arvi_pkg::width_bu;
			2: return arvi_pkg::width_h;
			3: return arvi_pkg::width_hu;
			default: return arvi_pkg::width_w;
		endcase
	endfunction

	function automatic arvi_pkg::ls_cmd_t make_cmd(input logic [31:0] addr,
			input logic [31:0] wdata, input arvi_pkg::mem_width_e w, input logic st);
		arvi_pkg::ls_cmd_t c;
		c.addr = addr;
		c.wdata = wdata;
		c.width = w;
		c.is_store = st;
		return c;
	endfunction

	// Lanes follow the low address bits, data repeats in every lane
	function automatic arvi_pkg::bus_req_t expected_bus(input arvi_pkg::ls_cmd_t c);
		arvi_pkg::bus_req_t r;
		int n;
		n = byte_count(c.width);
		r.addr = {c.addr[31:2], 2'b00};
		r.wr_en = 1'b1;
		r.byte_en = (n == 1) ? 4'b0001 << c.addr[1:0] :
			(n == 2) ? 4'b0011 << c.addr[1:0] : 4'b1111;
		r.wdata = (n == 1) ? {4{c.wdata[7:0]}} :
			(n == 2) ? {2{c.wdata[15:0]}} : c.wdata;
		return r;
	endfunction

	function automatic logic [31:0] expected_load(input arvi_pkg::ls_cmd_t c);
		logic [31:0] word;
		logic [7:0]  b;
		logic [15:0] h;
		word = mirror[c.addr[11:2]];
		b = word[c.addr[1:0]*8 +: 8];
		h = word[c.addr[1]*16 +: 16];
		case (c.width)
			arvi_pkg::width_b: return {{24{b[7]}}, b};
			arvi_pkg::width_bu: return {24'h0, b};
			arvi_pkg::width_h: return {{16{h[15]}}, h};
			arvi_pkg::width_hu: return {16'h0, h};
			default: return word;
		endcase
	endfunction

	task automatic apply_store(input arvi_pkg::ls_cmd_t c);
		arvi_pkg::bus_req_t r;
		r = expected_bus(c);
		for (int b = 0; b < 4; b++) begin
			if (r.byte_en[b])
				mirror[c.addr[11:2]][b*8 +: 8] = r.wdata[b*8 +: 8];
		end
	endtask

	task automatic fail_run(input string why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_fetch(input string name, input arvi_pkg::fetch_t exp,
			input arvi_pkg::fetch_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h actual %h", name, exp, act);
			fail_run("fetched word does not match");
		end
	endtask

	task automatic check_ls_rsp(input string name, input arvi_pkg::ls_rsp_t exp,
			input arvi_pkg::ls_rsp_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h actual %h", name, exp, act);
			fail_run("load/store response does not match");
		end
	endtask

	task automatic check_bus_req(input string name, input arvi_pkg::bus_req_t exp,
			input arvi_pkg::bus_req_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h actual %h", name, exp, act);
			fail_run("bus request does not match");
		end
	endtask

	// Take one fetched word, optionally after a random stall
	task automatic fetch_one(input string name, input bit stall);
		arvi_pkg::fetch_t exp;
		int n;
		n = 0;
		while (!fetch_valid) begin
			@(negedge clk);
			n++;
			if (n > LIMIT)
				fail_run("timeout waiting for a fetched word");
		end
		exp.pc = exp_pc;
		exp.instr = mirror[exp_pc[11:2]];
		check_fetch(name, exp, fetch);
		if (stall)
			repeat ($urandom % 3) @(negedge clk);
		fetch_ready = 1'b1;
		@(negedge clk);
		fetch_ready = 1'b0;
		exp_pc = exp_pc + 32'd4;
	endtask

	task automatic ls_access(input string name, input arvi_pkg::ls_cmd_t c,
			input bit check_bus, input bit quiet, output arvi_pkg::ls_rsp_t rsp);
		int n;
		n = 0;
		while (!ls_ready) begin
			@(negedge clk);
			n++;
			if (n > LIMIT)
				fail_run("timeout waiting for the load/store port to be ready");
		end
		ls_valid = 1'b1;
		ls_cmd = c;
		@(negedge clk);
		ls_valid = 1'b0;
		if (check_bus) begin
			n = 0;
			while (!(bus_en && bus_req.wr_en)) begin
				@(negedge clk);
				n++;
				if (n > LIMIT)
					fail_run("timeout waiting for the store on the bus");
			end
			check_bus_req(name, expected_bus(c), bus_req);
		end
		n = 0;
		while (!ls_rsp_valid) begin
			if (quiet && bus_en)
				fail_run("bus access made for a misaligned command");
			@(negedge clk);
			n++;
			if (n > LIMIT)
				fail_run("timeout waiting for the load/store response");
		end
		if (quiet && bus_en)
			fail_run("bus access made for a misaligned command");
		// Misaligned answer comes back one cycle after acceptance
		if (quiet && n != 0)
			fail_run("misaligned command was not answered one cycle after acceptance");
		rsp = ls_rsp;
		// Consumer stalls for a few cycles while the response stays put
		repeat ($urandom % 3) begin
			@(negedge clk);
			if (!ls_rsp_valid || ls_ready || ls_rsp !== rsp)
				fail_run("load/store response not held while the consumer stalls");
			if (quiet && bus_en)
				fail_run("bus access made for a misaligned command");
		end
		ls_rsp_ready = 1'b1;
		@(negedge clk);
		ls_rsp_ready = 1'b0;
	endtask

	task automatic store_and_check(input string name, input arvi_pkg::ls_cmd_t c,
			input bit check_bus);
		arvi_pkg::ls_rsp_t rsp;
		ls_access(name, c, check_bus, 1'b0, rsp);
		check_ls_rsp(name, '0, rsp);
		apply_store(c);
	endtask

	task automatic load_and_check(input string name, input arvi_pkg::ls_cmd_t c);
		arvi_pkg::ls_rsp_t rsp;
		arvi_pkg::ls_rsp_t exp;
		ls_access(name, c, 1'b0, 1'b0, rsp);
		exp.rdata = expected_load(c);
		exp.misaligned = 1'b0;
		check_ls_rsp(name, exp, rsp);
	endtask

	task automatic test_sequential();
		for (int i = 0; i < 6; i++)
			fetch_one("sequential", i > 2);
	endtask

	task automatic test_redirect();
		fetch_one("redirect", 1'b0);
		// Request granted by now, word still in flight
		@(negedge clk);
		redirect_valid = 1'b1;
		redirect_pc = 32'h0000_0400;
		@(negedge clk);
		redirect_valid = 1'b0;
		exp_pc = 32'h0000_0400;
		fetch_one("redirect", 1'b0);
		redirect_valid = 1'b1;
		redirect_pc = 32'h0000_0200;
		@(negedge clk);
		redirect_valid = 1'b0;
		exp_pc = 32'h0000_0200;
		fetch_one("redirect", 1'b0);
		fetch_one("redirect", 1'b0);
	endtask

	task automatic test_stores();
		for (int off = 0; off < 4; off++)
			store_and_check("store byte", make_cmd(32'h800 + off, $urandom,
				arvi_pkg::width_b, 1'b1), 1'b1);
		for (int off = 0; off < 4; off += 2)
			store_and_check("store half", make_cmd(32'h804 + off, $urandom,
				arvi_pkg::width_h, 1'b1), 1'b1);
		store_and_check("store word", make_cmd(32'h808, $urandom,
			arvi_pkg::width_w, 1'b1), 1'b1);
	endtask

	task automatic test_loads();
		arvi_pkg::mem_width_e w;
		for (int wd = 0; wd < 3; wd++) begin
			for (int off = 0; off < 4; off++) begin
				for (int k = 0; k < 5; k++) begin
					w = width_at(k);
					if (off % byte_count(w) == 0)
						load_and_check("load", make_cmd(32'h800 + wd * 4 + off, '0, w, 1'b0));
				end
			end
		end
	endtask

	task automatic test_misaligned();
		arvi_pkg::ls_rsp_t rsp;
		arvi_pkg::ls_rsp_t exp;
		int n;
		// Fetch parks on a held word so the bus goes quiet
		n = 0;
		while (!fetch_valid || bus_en) begin
			@(negedge clk);
			n++;
			if (n > LIMIT)
				fail_run("timeout waiting for the bus to go idle");
		end
		exp.rdata = '0;
		exp.misaligned = 1'b1;
		for (int off = 1; off < 4; off++) begin
			if (off % 2 == 1) begin
				ls_access("misaligned half", make_cmd(32'h800 + off, '0,
					arvi_pkg::width_h, 1'b0), 1'b0, 1'b1, rsp);
				check_ls_rsp("misaligned half", exp, rsp);
			end
			ls_access("misaligned word", make_cmd(32'h800 + off, '0,
				arvi_pkg::width_w, 1'b0), 1'b0, 1'b1, rsp);
			check_ls_rsp("misaligned word", exp, rsp);
		end
	endtask

	task automatic test_contention();
		fork
			begin
				for (int i = 0; i < 10; i++)
					fetch_one("contention fetch", 1'b1);
			end
			begin
				for (int i = 0; i < 6; i++) begin
					store_and_check("contention store", make_cmd(32'h900 + i * 4, $urandom,
						arvi_pkg::width_w, 1'b1), 1'b0);
					load_and_check("contention load", make_cmd(32'h900 + i * 4 + 2, '0,
						arvi_pkg::width_hu, 1'b0));
				end
			end
		join
	endtask

	initial begin
		void'($urandom(32'hbd40_cff3));
		clk = 1'b0;
		rst_n = 1'b0;
		fetch_ready = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		ls_valid = 1'b0;
		ls_cmd = '0;
		ls_rsp_ready = 1'b0;
		exp_pc = PC_START;
		for (int i = 0; i < 1024; i++)
			mirror[i[9:0]] = initial_word(i * 4);
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		test_sequential();
		test_redirect();
		test_stores();
		test_loads();
		test_misaligned();
		test_contention();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
design/arvi_pkg.sv
design/instr_fetch.sv
design/load_store_unit.sv
design/bus_arbiter.sv
design/risc_v_mem_port.sv
tests/bus_memory_model.sv
tests/bus_checker.sv
tests/tb_risc_v_mem_port.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_risc_v_mem_port
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
